// ==== hw/kbd_config.svh ====
/*
 * keyboard adapter configuration
 * matrix geometry, PS/2 prefix bytes and input synchronizer depth
 */
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// number of rows in the key matrix, one row_bits_t each
`define KBD_ROWS 8

// prefix byte sent before the scan code of a released key
`define KBD_BREAK_CODE 8'hF0

// prefix byte of the extended (grey) key set
`define KBD_EXT_CODE 8'hE0

// flops on each asynchronous PS/2 line, must be 2 or more
`define KBD_SYNC_STAGES 2

`endif

// ==== hw/kbd_pkg.sv ====
/*
 * keyboard adapter types
 * scan codes, matrix coordinates, modifier ids and the lookup entry
 */
package kbd_pkg;

	// one PS/2 scan code byte
	typedef logic [7:0] scan_code_t;

	// matrix coordinates
	typedef logic [2:0] row_idx_t;
	typedef logic [2:0] col_idx_t;

	// one bit per column, also used for the row select byte
	typedef logic [7:0] row_bits_t;

	typedef enum logic [1:0] {mod_shift, mod_ctrl, mod_rus, mod_blksbr} mod_id_t;

	typedef enum logic [1:0] {kind_none, kind_matrix, kind_modifier} entry_kind_t;

	// -----------------------------------------------------------
	// lookup entry, kind always in the top two bits
	// -----------------------------------------------------------
	// sshift marks keys that need a computer-side shift
	typedef struct packed {
		entry_kind_t kind;
		row_idx_t    row;
		col_idx_t    col;
		logic        sshift;
	} matrix_view_t;

	typedef struct packed {
		entry_kind_t kind;
		mod_id_t     id;
		logic [4:0]  pad;
	} modifier_view_t;

	// two kind bits over a seven bit payload
	typedef union packed {
		matrix_view_t   mat;
		modifier_view_t mods;
	} map_entry_u;

endpackage

// ==== hw/ps2_receiver.sv ====
/*
 * PS/2 receiver
 * synchronizes the keyboard lines, shifts in 11-bit frames and
 * offers each good byte on a valid/ready channel
 */
`timescale 1ns/100ps
`include "kbd_config.svh"

module ps2_receiver (
	input  logic                clkk,
	input  logic                reset,
	input  logic                ps2_clk,
	input  logic                ps2_dat,
	input  logic                scan_ready,
	output logic                scan_valid,
	output kbd_pkg::scan_code_t scan_code
);

	// synchronizer chains, newest sample in bit 0
	logic [`KBD_SYNC_STAGES-1:0] clk_sync;
	logic [`KBD_SYNC_STAGES-1:0] dat_sync;
	logic       clk_prev;
	logic       fall;
	logic [3:0] bit_cnt;
	// last ten bits received, start bit ends up in bit 0
	logic [9:0]  frame;
	logic [10:0] frame_next;
	logic        frame_ok;
	logic        load;

	// keyboard changes data while its clock is high, sample on the fall
	assign fall = clk_prev & ~clk_sync[`KBD_SYNC_STAGES-1];

	// whole frame as it stands once the current bit is in
	assign frame_next = {dat_sync[`KBD_SYNC_STAGES-1], frame};

	// start 0, odd parity over data and parity bit, stop 1
	assign frame_ok = ~frame_next[0] & (^frame_next[9:1]) & frame_next[10];

	// stop bit arriving on a good frame with an empty holding register
	assign load = fall && (bit_cnt == 4'd10) && frame_ok && !scan_valid;

	// -----------------------------------------------------------
	// control: sync, bit counter, valid
	// -----------------------------------------------------------
	always_ff @(posedge clkk) begin
		if (reset) begin
			// idle lines are high
			clk_sync   <= '1;
			dat_sync   <= '1;
			clk_prev   <= 1'b1;
			bit_cnt    <= 4'd0;
			scan_valid <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[`KBD_SYNC_STAGES-2:0], ps2_clk};
			dat_sync <= {dat_sync[`KBD_SYNC_STAGES-2:0], ps2_dat};
			clk_prev <= clk_sync[`KBD_SYNC_STAGES-1];

			if (scan_valid && scan_ready)
				scan_valid <= 1'b0;

			if (fall) begin
				if (bit_cnt == 4'd10)
					bit_cnt <= 4'd0;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end

			// a bad frame or a full register just drops the byte
			if (load)
				scan_valid <= 1'b1;
		end
	end

	// payload shift register and holding register
	always_ff @(posedge clkk) begin
		if (fall)
			frame <= frame_next[10:1];
		if (load)
			scan_code <= frame_next[8:1];
	end

endmodule

// ==== hw/scan_to_matrix.sv ====
/*
 * scan code lookup
 * maps a PS/2 set 2 code to a matrix cell or a modifier,
 * shared by make and break
 */
`timescale 1ns/100ps

module scan_to_matrix (
	input  kbd_pkg::scan_code_t lookup_code,
	output kbd_pkg::map_entry_u lookup_entry
);

	function automatic kbd_pkg::map_entry_u mat_key(
		input kbd_pkg::row_idx_t row,
		input kbd_pkg::col_idx_t col,
		input logic              sshift
	);
		kbd_pkg::map_entry_u e;
		e.mat.kind   = kbd_pkg::kind_matrix;
		e.mat.row    = row;
		e.mat.col    = col;
		e.mat.sshift = sshift;
		return e;
	endfunction

	function automatic kbd_pkg::map_entry_u mod_key(input kbd_pkg::mod_id_t id);
		kbd_pkg::map_entry_u e;
		e.mods.kind = kbd_pkg::kind_modifier;
		e.mods.id   = id;
		e.mods.pad  = '0;
		return e;
	endfunction

	always_comb begin
		// kind_none, also for both prefixes
		lookup_entry = '0;
		case (lookup_code)
			// modifiers, both shifts share one flag
			8'h12: lookup_entry = mod_key(kbd_pkg::mod_shift);
			8'h59: lookup_entry = mod_key(kbd_pkg::mod_shift);
			8'h14: lookup_entry = mod_key(kbd_pkg::mod_ctrl);
			8'h58: lookup_entry = mod_key(kbd_pkg::mod_rus);
			8'h07: lookup_entry = mod_key(kbd_pkg::mod_blksbr);
			// row 0 editing keys
			8'h5A: lookup_entry = mat_key(3'd0, 3'd1, 1'b0);
			8'h66: lookup_entry = mat_key(3'd0, 3'd3, 1'b0);
			// digits 0..7 on row 2
			8'h45: lookup_entry = mat_key(3'd2, 3'd0, 1'b0);
			8'h16: lookup_entry = mat_key(3'd2, 3'd1, 1'b0);
			8'h1E: lookup_entry = mat_key(3'd2, 3'd2, 1'b0);
			8'h26: lookup_entry = mat_key(3'd2, 3'd3, 1'b0);
			8'h25: lookup_entry = mat_key(3'd2, 3'd4, 1'b0);
			8'h2E: lookup_entry = mat_key(3'd2, 3'd5, 1'b0);
			8'h36: lookup_entry = mat_key(3'd2, 3'd6, 1'b0);
			8'h3D: lookup_entry = mat_key(3'd2, 3'd7, 1'b0);
			// apostrophe is shifted 7 on the computer
			8'h52: lookup_entry = mat_key(3'd2, 3'd7, 1'b1);
			// row 3: 8 9 : ; , - . /
			8'h3E: lookup_entry = mat_key(3'd3, 3'd0, 1'b0);
			8'h46: lookup_entry = mat_key(3'd3, 3'd1, 1'b0);
			8'h4C: lookup_entry = mat_key(3'd3, 3'd3, 1'b0);
			8'h4E: lookup_entry = mat_key(3'd3, 3'd5, 1'b0);
			// equals is shifted minus
			8'h55: lookup_entry = mat_key(3'd3, 3'd5, 1'b1);
			// letters, @ A..G on row 4
			8'h0E: lookup_entry = mat_key(3'd4, 3'd0, 1'b0);
			8'h1C: lookup_entry = mat_key(3'd4, 3'd1, 1'b0);
			8'h32: lookup_entry = mat_key(3'd4, 3'd2, 1'b0);
			8'h21: lookup_entry = mat_key(3'd4, 3'd3, 1'b0);
			8'h23: lookup_entry = mat_key(3'd4, 3'd4, 1'b0);
			8'h24: lookup_entry = mat_key(3'd4, 3'd5, 1'b0);
			8'h2B: lookup_entry = mat_key(3'd4, 3'd6, 1'b0);
			8'h34: lookup_entry = mat_key(3'd4, 3'd7, 1'b0);
			// H..O
			8'h33: lookup_entry = mat_key(3'd5, 3'd0, 1'b0);
			8'h43: lookup_entry = mat_key(3'd5, 3'd1, 1'b0);
			8'h3B: lookup_entry = mat_key(3'd5, 3'd2, 1'b0);
			8'h42: lookup_entry = mat_key(3'd5, 3'd3, 1'b0);
			8'h4B: lookup_entry = mat_key(3'd5, 3'd4, 1'b0);
			8'h3A: lookup_entry = mat_key(3'd5, 3'd5, 1'b0);
			8'h31: lookup_entry = mat_key(3'd5, 3'd6, 1'b0);
			8'h44: lookup_entry = mat_key(3'd5, 3'd7, 1'b0);
			// P..W
			8'h4D: lookup_entry = mat_key(3'd6, 3'd0, 1'b0);
			8'h15: lookup_entry = mat_key(3'd6, 3'd1, 1'b0);
			8'h2D: lookup_entry = mat_key(3'd6, 3'd2, 1'b0);
			8'h1B: lookup_entry = mat_key(3'd6, 3'd3, 1'b0);
			8'h2C: lookup_entry = mat_key(3'd6, 3'd4, 1'b0);
			8'h3C: lookup_entry = mat_key(3'd6, 3'd5, 1'b0);
			8'h2A: lookup_entry = mat_key(3'd6, 3'd6, 1'b0);
			8'h1D: lookup_entry = mat_key(3'd6, 3'd7, 1'b0);
			// X Y Z and space
			8'h22: lookup_entry = mat_key(3'd7, 3'd0, 1'b0);
			8'h35: lookup_entry = mat_key(3'd7, 3'd1, 1'b0);
			8'h1A: lookup_entry = mat_key(3'd7, 3'd2, 1'b0);
			8'h29: lookup_entry = mat_key(3'd7, 3'd7, 1'b0);
			default: lookup_entry = '0;
		endcase
	end

endmodule

// ==== hw/key_matrix.sv ====
/*
 * key matrix
 * make/break sequencer, 8x8 key storage, modifier flags and the
 * registered readout of the selected rows
 */
`timescale 1ns/100ps
`include "kbd_config.svh"

module key_matrix (
	input  logic                clkk,
	input  logic                reset,
	input  logic                scan_valid,
	input  kbd_pkg::scan_code_t scan_code,
	output logic                scan_ready,
	output kbd_pkg::scan_code_t lookup_code,
	input  kbd_pkg::map_entry_u lookup_entry,
	input  kbd_pkg::row_bits_t  rowselect,
	output kbd_pkg::row_bits_t  rowbits,
	output logic                key_shift,
	output logic                key_ctrl,
	output logic                key_rus,
	output logic                key_blksbr
);

	kbd_pkg::row_bits_t matrix [`KBD_ROWS];
	kbd_pkg::row_bits_t col_onehot;
	kbd_pkg::row_bits_t row_or;
	// high during the update step that follows each transfer
	logic busy;
	// prefix flags
	logic brk;
	logic ext;
	// shift as sent by the keyboard
	logic ps2_shift;
	// set while a key that needs computer-side shift is down
	logic held_sshift;

	assign scan_ready = ~busy;

	// computer sees the keyboard shift flipped by a synthesized one
	assign key_shift = ps2_shift ^ held_sshift;

	// one-hot column of the looked-up cell
	always_comb begin
		col_onehot = '0;
		col_onehot[lookup_entry.mat.col] = 1'b1;
	end

	// byte is held for the lookup during the update step
	always_ff @(posedge clkk) begin
		if (scan_valid && scan_ready)
			lookup_code <= scan_code;
	end

	// -----------------------------------------------------------
	// sequencer and key state
	// -----------------------------------------------------------
	always_ff @(posedge clkk) begin
		if (reset) begin
			busy        <= 1'b0;
			brk         <= 1'b0;
			ext         <= 1'b0;
			ps2_shift   <= 1'b0;
			key_ctrl    <= 1'b0;
			key_rus     <= 1'b0;
			key_blksbr  <= 1'b0;
			held_sshift <= 1'b0;
			for (int r = 0; r < `KBD_ROWS; r++)
				matrix[r] <= '0;
		end else if (!busy) begin
			// idle, take a byte
			if (scan_valid)
				busy <= 1'b1;
		end else begin
			busy <= 1'b0;
			if (lookup_code == `KBD_BREAK_CODE) begin
				brk <= 1'b1;
			end else if (lookup_code == `KBD_EXT_CODE) begin
				ext <= 1'b1;
			end else begin
				brk <= 1'b0;
				ext <= 1'b0;
				case (lookup_entry.mat.kind)
					kbd_pkg::kind_matrix: begin
						if (brk)
							matrix[lookup_entry.mat.row] <=
								matrix[lookup_entry.mat.row] & ~col_onehot;
						else
							matrix[lookup_entry.mat.row] <=
								matrix[lookup_entry.mat.row] | col_onehot;
						// synthesized shift lives until that key's release
						if (lookup_entry.mat.sshift)
							held_sshift <= ~brk;
					end
					kbd_pkg::kind_modifier: begin
						case (lookup_entry.mods.id)
							// E0 12 and E0 59 are fake shifts around grey keys
							kbd_pkg::mod_shift: if (!ext) ps2_shift <= ~brk;
							kbd_pkg::mod_ctrl: key_ctrl <= ~brk;
							kbd_pkg::mod_rus: key_rus <= ~brk;
							kbd_pkg::mod_blksbr: key_blksbr <= ~brk;
							default: ;
						endcase
					end
					// unknown keys only clear the prefixes
					default: ;
				endcase
			end
		end
	end

	// -----------------------------------------------------------
	// row readout
	// -----------------------------------------------------------
	// OR of every row whose select bit is set
	always_comb begin
		row_or = '0;
		for (int r = 0; r < `KBD_ROWS; r++) begin
			if (rowselect[r])
				row_or = row_or | matrix[r];
		end
	end

	always_ff @(posedge clkk) begin
		if (reset)
			rowbits <= '0;
		else
			rowbits <= row_or;
	end

endmodule

// ==== hw/vector_keyboard.sv ====
/*
 * keyboard adapter top level
 * PS/2 receiver feeding the scan code lookup and the key matrix
 */
`timescale 1ns/100ps

module vector_keyboard (
	input  logic               clkk,
	input  logic               reset,
	input  logic               ps2_clk,
	input  logic               ps2_dat,
	input  kbd_pkg::row_bits_t rowselect,
	output kbd_pkg::row_bits_t rowbits,
	output logic               key_shift,
	output logic               key_ctrl,
	output logic               key_rus,
	output logic               key_blksbr
);

	// byte channel
	logic                scan_valid;
	logic                scan_ready;
	kbd_pkg::scan_code_t scan_code;
	// lookup path
	kbd_pkg::scan_code_t lookup_code;
	kbd_pkg::map_entry_u lookup_entry;

	ps2_receiver u_ps2_receiver (
		.clkk       (clkk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.scan_ready (scan_ready),
		.scan_valid (scan_valid),
		.scan_code  (scan_code)
	);

	scan_to_matrix u_scan_to_matrix (
		.lookup_code  (lookup_code),
		.lookup_entry (lookup_entry)
	);

	key_matrix u_key_matrix (
		.clkk         (clkk),
		.reset        (reset),
		.scan_valid   (scan_valid),
		.scan_code    (scan_code),
		.scan_ready   (scan_ready),
		.lookup_code  (lookup_code),
		.lookup_entry (lookup_entry),
		.rowselect    (rowselect),
		.rowbits      (rowbits),
		.key_shift    (key_shift),
		.key_ctrl     (key_ctrl),
		.key_rus      (key_rus),
		.key_blksbr   (key_blksbr)
	);

endmodule

// ==== tests/vector_keyboard_assertions.sv ====
/*
 * key matrix assertions
 * byte channel stability, ready drop after a transfer and the reset state
 */
`timescale 1ns/100ps

module vector_keyboard_assertions (
	input logic                clkk,
	input logic                reset,
	input logic                scan_valid,
	input kbd_pkg::scan_code_t scan_code,
	input logic                scan_ready,
	input kbd_pkg::row_bits_t  rowbits,
	input logic                key_shift,
	input logic                key_ctrl,
	input logic                key_rus,
	input logic                key_blksbr
);

	// number of assertion failures so far
	int fail_count = 0;

	// stalled byte stays put until the matrix takes it
	a_hold: assert property (@(posedge clkk) disable iff (reset)
		scan_valid && !scan_ready |=> scan_valid && $stable(scan_code))
		else begin
			fail_count++;
			$error("byte channel changed while stalled");
		end

	// update step always follows a transfer
	a_ready_drop: assert property (@(posedge clkk) disable iff (reset)
		scan_valid && scan_ready |=> !scan_ready)
		else begin
			fail_count++;
			$error("scan_ready still high after a transfer");
		end

	// synchronous reset clears readout and flags
	a_reset: assert property (@(posedge clkk)
		reset |=> rowbits == '0 && !key_shift && !key_ctrl && !key_rus && !key_blksbr)
		else begin
			fail_count++;
			$error("outputs not cleared after reset");
		end

endmodule

// ==== tests/vector_keyboard_tb.sv ====
/*
 * keyboard adapter testbench
 * drives PS/2 frames into the top level and checks the row readout
 * and the modifier flags against a reference model
 */
`timescale 1ns/100ps
`include "kbd_config.svh"

module vector_keyboard_tb;

	// frames sent over the whole run
	localparam int NUM_FRAMES = 54;
	// 11 bits of 16 cycles and the settle and readout time of each frame
	localparam int TIMEOUT_NS = NUM_FRAMES * 11 * 16 * 100
		+ NUM_FRAMES * 64 * 100 + 200000;

	logic               clkk = 1'b0;
	logic               reset;
	logic               ps2_clk;
	logic               ps2_dat;
	kbd_pkg::row_bits_t rowselect;
	kbd_pkg::row_bits_t rowbits;
	logic               key_shift;
	logic               key_ctrl;
	logic               key_rus;
	logic               key_blksbr;

	integer seed = 32'h47f33442;
	int     errors = 0;
	int     test_start = 0;
	int     pass_cnt = 0;
	int     fail_cnt = 0;

	// -----------------------------------------------------------
	// reference model
	// -----------------------------------------------------------
	kbd_pkg::row_bits_t model_rows [`KBD_ROWS];
	logic m_shift;
	logic m_ctrl;
	logic m_rus;
	logic m_blksbr;
	// synthesized shift held by a pressed key
	logic m_held;

	vector_keyboard u_vector_keyboard (
		.clkk       (clkk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.rowselect  (rowselect),
		.rowbits    (rowbits),
		.key_shift  (key_shift),
		.key_ctrl   (key_ctrl),
		.key_rus    (key_rus),
		.key_blksbr (key_blksbr)
	);

	bind key_matrix vector_keyboard_assertions u_kbd_assertions (
		.clkk       (clkk),
		.reset      (reset),
		.scan_valid (scan_valid),
		.scan_code  (scan_code),
		.scan_ready (scan_ready),
		.rowbits    (rowbits),
		.key_shift  (key_shift),
		.key_ctrl   (key_ctrl),
		.key_rus    (key_rus),
		.key_blksbr (key_blksbr)
	);

	// 100 ns system clock
	always #50 clkk = ~clkk;

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the test sequence did not complete in time");
		$display("test failed");
		$finish;
	end

	// key list as {code, row, column, synthesized shift}
	function automatic logic [14:0] key_info(input int idx);
		case (idx)
			0: return {8'h1C, 3'd4, 3'd1, 1'b0};
			1: return {8'h32, 3'd4, 3'd2, 1'b0};
			2: return {8'h16, 3'd2, 3'd1, 1'b0};
			3: return {8'h45, 3'd2, 3'd0, 1'b0};
			// apostrophe and equals need a computer-side shift
			4: return {8'h52, 3'd2, 3'd7, 1'b1};
			5: return {8'h55, 3'd3, 3'd5, 1'b1};
			6: return {8'h33, 3'd5, 3'd0, 1'b0};
			7: return {8'h4D, 3'd6, 3'd0, 1'b0};
			8: return {8'h22, 3'd7, 3'd0, 1'b0};
			9: return {8'h29, 3'd7, 3'd7, 1'b0};
			10: return {8'h5A, 3'd0, 3'd1, 1'b0};
			default: return {8'h66, 3'd0, 3'd3, 1'b0};
		endcase
	endfunction

	// codes of shift, right shift, ctrl, caps lock and F12
	function automatic kbd_pkg::scan_code_t mod_code(input int idx);
		case (idx)
			0: return 8'h12;
			1: return 8'h59;
			2: return 8'h14;
			3: return 8'h58;
			default: return 8'h07;
		endcase
	endfunction

	function automatic kbd_pkg::row_bits_t model_or(input kbd_pkg::row_bits_t sel);
		kbd_pkg::row_bits_t acc;
		acc = '0;
		for (int r = 0; r < `KBD_ROWS; r++)
			if (sel[r])
				acc = acc | model_rows[r];
		return acc;
	endfunction

	// ends 10 ns after a rising edge where inputs change
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clkk);
		#10;
	endtask

	// start bit, 8 data bits LSB first, odd parity and stop bit
	task automatic send_frame(input kbd_pkg::scan_code_t code, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			// data changes while the PS/2 clock is high
			ps2_dat = bits[i];
			wait_cycles(8);
			ps2_clk = 1'b0;
			wait_cycles(8);
			ps2_clk = 1'b1;
		end
		ps2_dat = 1'b1;
		wait_cycles(20);
	endtask

	task automatic press_key(input int idx, input logic brk);
		logic [14:0] info;
		info = key_info(idx);
		if (brk)
			send_frame(`KBD_BREAK_CODE, 1'b0);
		send_frame(info[14:7], 1'b0);
		model_rows[info[6:4]][info[3:1]] = ~brk;
		if (info[0])
			m_held = ~brk;
	endtask

	task automatic press_mod(input kbd_pkg::scan_code_t code, input logic brk);
		if (brk)
			send_frame(`KBD_BREAK_CODE, 1'b0);
		send_frame(code, 1'b0);
		case (code)
			8'h12, 8'h59: m_shift = ~brk;
			8'h14: m_ctrl = ~brk;
			8'h58: m_rus = ~brk;
			8'h07: m_blksbr = ~brk;
			default: ;
		endcase
	endtask

	// readout is registered one edge after rowselect
	task automatic read_rows(input kbd_pkg::row_bits_t sel, output kbd_pkg::row_bits_t got);
		rowselect = sel;
		wait_cycles(1);
		got = rowbits;
	endtask

	task automatic check_row(input string name, input kbd_pkg::row_bits_t exp,
		input kbd_pkg::row_bits_t act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// every row one at a time and then the four flags
	task automatic check_all();
		kbd_pkg::row_bits_t sel;
		kbd_pkg::row_bits_t got;
		for (int r = 0; r < `KBD_ROWS; r++) begin
			sel = '0;
			sel[r] = 1'b1;
			read_rows(sel, got);
			check_row($sformatf("rowbits sel row %0d", r), model_rows[r], got);
		end
		check_flag("key_shift", m_shift ^ m_held, key_shift);
		check_flag("key_ctrl", m_ctrl, key_ctrl);
		check_flag("key_rus", m_rus, key_rus);
		check_flag("key_blksbr", m_blksbr, key_blksbr);
	endtask

	task automatic end_test(input string name);
		if (errors == test_start) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: %0d errors", name, errors - test_start);
		end
		test_start = errors;
	endtask

	// -----------------------------------------------------------
	// test sequence
	// -----------------------------------------------------------
	initial begin
		kbd_pkg::row_bits_t sel;
		kbd_pkg::row_bits_t got;
		logic [14:0] info;
		int k1;
		int k2;
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		rowselect = '0;
		for (int r = 0; r < `KBD_ROWS; r++)
			model_rows[r] = '0;
		m_shift = 1'b0;
		m_ctrl = 1'b0;
		m_rus = 1'b0;
		m_blksbr = 1'b0;
		m_held = 1'b0;
		repeat (5) @(posedge clkk);
		#10;
		reset = 1'b0;
		wait_cycles(2);
		check_all();
		end_test("reset state");

		// single presses that accumulate keys
		for (int i = 0; i < 6; i++) begin
			press_key({$random(seed)} % 12, 1'b0);
			check_all();
		end
		end_test("make");

		// release one of two held keys
		for (int i = 0; i < 4; i++) begin
			k1 = {$random(seed)} % 12;
			k2 = (k1 + 1 + {$random(seed)} % 11) % 12;
			press_key(k1, 1'b0);
			press_key(k2, 1'b0);
			press_key(k1, 1'b1);
			check_all();
		end
		end_test("break");

		for (int i = 0; i < 5; i++) begin
			press_mod(mod_code(i), 1'b0);
			check_all();
			press_mod(mod_code(i), 1'b1);
			check_all();
		end
		end_test("modifiers");

		// at least two rows per select
		for (int i = 0; i < 8; i++) begin
			sel = kbd_pkg::row_bits_t'($random(seed));
			sel[i] = 1'b1;
			sel[(i + 3) % 8] = 1'b1;
			read_rows(sel, got);
			check_row($sformatf("rowbits sel %h", sel), model_or(sel), got);
		end
		end_test("multi-row select");

		// dropped frames leave the model untouched
		for (int i = 0; i < 4; i++) begin
			info = key_info({$random(seed)} % 12);
			if (i % 2)
				send_frame(mod_code(i), 1'b1);
			else
				send_frame(info[14:7], 1'b1);
			check_all();
		end
		end_test("bad parity");

		// start with both shifted keys up
		press_key(4, 1'b1);
		press_key(5, 1'b1);
		check_all();
		press_mod(8'h12, 1'b0);
		check_all();
		// apostrophe cancels the PC shift
		press_key(4, 1'b0);
		check_all();
		press_key(4, 1'b1);
		check_all();
		press_mod(8'h12, 1'b1);
		check_all();
		// equals alone raises shift
		press_key(5, 1'b0);
		check_all();
		press_key(5, 1'b1);
		check_all();
		end_test("synthesized shift");

		errors = errors + u_vector_keyboard.u_key_matrix.u_kbd_assertions.fail_count;
		$display("tests ok %0d, tests with errors %0d, total errors %0d",
			pass_cnt, fail_cnt, errors);
		if (errors == 0 && fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hw
hw/kbd_pkg.sv
hw/ps2_receiver.sv
hw/scan_to_matrix.sv
hw/key_matrix.sv
hw/vector_keyboard.sv
tests/vector_keyboard_assertions.sv
tests/vector_keyboard_tb.sv

// ==== Bender.yml ====
package:
  name: vector_keyboard

sources:
  - include_dirs:
      - hw
    files:
      - hw/kbd_pkg.sv
      - hw/ps2_receiver.sv
      - hw/scan_to_matrix.sv
      - hw/key_matrix.sv
      - hw/vector_keyboard.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/vector_keyboard_assertions.sv
      - tests/vector_keyboard_tb.sv
